//--- testbench/demod_testdata.txt
# T name | W addr data | L carrierLock | S random sample | R amplitude direction
# C addr expected readback; all numbers in hex
T regs
W 300 5
W 301 210
W 302 8000
C 300 5
C 301 210
C 302 8000
C 310 0
C 305 0
L 1
C 304 2
T video
S
S
S
W 300 0
S
S
S
T dacsel
W 301 f43
W 302 1000
S
S
S
T average
W 300 1
S
S
S
T offset
W 302 8000
W 303 4000
C 303 4000
R 1d4c0 0
R 1d4c0 0
C 304 3
R 10000 0
R 10000 0
C 304 2
L 0
R 10000 0
C 304 1
R 2000 0
C 304 0

//--- flist.f
+incdir+source
source/demodPkg.sv
source/demodRegs.sv
source/fmDiscriminator.sv
source/falseLockDetector.sv
source/dacMux.sv
source/demodTop.sv
testbench/demodChecker.sv
testbench/tbDemod.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f flist.f --top-module tbDemod -o simDemod

out=$(./obj_dir/simDemod 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qxF "PASS: all tests"; then
    exit 0
fi
exit 1

//--- testbench/tbDemod.sv
module tbDemod import demodPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clk = 1'b0;
    logic       rstN;
    demodBusT   bus;
    wordT       dout;
    iqSampleT   rx;
    logic       sampleEn;
    logic       carrierLock;
    sampleT     dacData [3];
    logic [2:0] dacSync;
    logic       rdCheck;
    wordT       rdExpect;
    int         checks;
    int         errors;

    string lines [$];
    string testName;
    int    seed;
    int    limit;
    int    cycles;
    int    tests;
    int    rotIdx;
    int    checksAtStart;
    int    errorsAtStart;
    logic  failed;

    demodTop i_dut (
        .*,
        .dac0Data (dacData[0]),
        .dac1Data (dacData[1]),
        .dac2Data (dacData[2]),
        .dac0Sync (dacSync[0]),
        .dac1Sync (dacSync[1]),
        .dac2Sync (dacSync[2])
    );

    demodChecker i_chk (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // run limit scales with the number of data lines
    always @(posedge clk) begin
        if (cycles >= limit) begin
            $display("timeout after %0d cycles before the test data was used up", cycles);
            $display("FAIL: see errors above");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // drop line endings and trailing blanks
    function automatic string trimLine(string s);
        byte last;
        while (s.len() > 0) begin
            last = s.getc(s.len() - 1);
            if (last != 8'h0a && last != 8'h0d && last != " ") begin
                break;
            end
            s = (s.len() > 1) ? s.substr(0, s.len() - 2) : "";
        end
        return s;
    endfunction

    task automatic busWrite(int addr, int data);
        bus.wr   = 1'b1;
        bus.addr = addrT'(addr);
        bus.din  = wordT'(data);
        @(negedge clk);
        bus.wr = 1'b0;
    endtask

    // checker compares dout on the next rising edge
    task automatic readBack(int addr, int expected);
        bus.addr = addrT'(addr);
        rdExpect = wordT'(expected);
        rdCheck  = 1'b1;
        @(negedge clk);
        rdCheck = 1'b0;
    endtask

    // one strobe, then enough idle cycles for the status bit to settle
    task automatic sendSample(sampleT i, sampleT q);
        rx.i     = i;
        rx.q     = q;
        sampleEn = 1'b1;
        @(negedge clk);
        sampleEn = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    // quarter turn per sample, dir set turns the other way
    task automatic rotateStep(int amp, int dir);
        sampleT i;
        sampleT q;
        i = '0;
        q = '0;
        case (rotIdx % 4)
            0: i = sampleT'(amp);
            1: q = sampleT'(amp);
            2: i = -sampleT'(amp);
            default: q = -sampleT'(amp);
        endcase
        if (dir != 0) begin
            q = -q;
        end
        rotIdx++;
        sendSample(i, q);
    endtask

    task automatic endTest();
        // let the average taps of the last sample drain
        repeat (2) @(negedge clk);
        if (testName != "") begin
            $display("test %s: %0d checks, %0d errors", testName,
                     checks - checksAtStart, errors - errorsAtStart);
            tests++;
        end
        checksAtStart = checks;
        errorsAtStart = errors;
        rotIdx        = 0;
    endtask

    task automatic runLine(string s);
        byte    kind;
        string  args;
        int     a;
        int     b;
        sampleT ri;
        sampleT rq;
        kind = s.getc(0);
        args = (s.len() > 2) ? s.substr(2, s.len() - 1) : "";
        a = 0;
        b = 0;
        void'($sscanf(args, "%h %h", a, b));
        case (kind)
            "T": begin
                endTest();
                testName = args;
            end
            "W": busWrite(a, b);
            "L": carrierLock = a[0];
            "S": begin
                ri = sampleT'($random(seed));
                rq = sampleT'($random(seed));
                sendSample(ri, rq);
            end
            "R": rotateStep(a, b);
            "C": readBack(a, b);
            default: begin
                $display("unknown line kind in the test data: %s", s);
                failed = 1'b1;
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        bus           = '0;
        rx            = '0;
        sampleEn      = 1'b0;
        carrierLock   = 1'b0;
        rdCheck       = 1'b0;
        rdExpect      = '0;
        rstN          = 1'b0;
        seed          = 32'h86f1;
        failed        = 1'b0;
        testName      = "";
        tests         = 0;
        rotIdx        = 0;
        checksAtStart = 0;
        errorsAtStart = 0;
        fd = $fopen("testbench/demod_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/demod_testdata.txt");
            failed = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line = trimLine(line);
                if (line.len() > 0 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit = lines.size() * 8 + 100;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        foreach (lines[n]) begin
            runLine(lines[n]);
        end
        endTest();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !failed && checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testbench/demodChecker.sv
`include "demod_cfg.svh"

module demodChecker import demodPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  demodBusT   bus,
    input  wordT       dout,
    input  iqSampleT   rx,
    input  logic       sampleEn,
    input  sampleT     dacData [3],
    input  logic [2:0] dacSync,
    input  logic       rdCheck,
    input  wordT       rdExpect,
    output int         checks,
    output int         errors
);

    timeunit 1ns;
    timeprecision 100ps;

    // reference state, one pipeline stage per clock
    demodModeT  mode;
    logic       iqSwap;
    dacSelT     sel [3];
    longint     gainIn;
    longint     prevI;
    longint     prevQ;
    longint     video;
    longint     avgF;
    longint     avgA;
    longint     absX;
    longint     iNow;
    longint     qNow;
    logic       videoEn;
    logic       avgEn;
    logic [2:0] expSync;
    longint     expData [3];

    // keep the low 18 bits as a signed value
    function automatic longint wrap18(longint v);
        return longint'(sampleT'(v));
    endfunction

    // single-pole average, unit gain is 2^17
    function automatic longint average(longint x, longint avg, longint gain);
        return wrap18((x * gain + avg * (longint'(`ALPHA_ONE) - gain)) >>> 17);
    endfunction

    always @(posedge clk) begin
        if (!rstN) begin
            mode    = MODE_FM;
            iqSwap  = 1'b0;
            sel     = '{default: '0};
            gainIn  = 0;
            prevI   = 0;
            prevQ   = 0;
            video   = 0;
            avgF    = 0;
            avgA    = 0;
            videoEn = 1'b0;
            avgEn   = 1'b0;
            expSync = '0;
            checks  = 0;
            errors  = 0;
        end else begin
            for (int d = 0; d < 3; d++) begin
                if (dacSync[d] !== expSync[d]) begin
                    errors++;
                    $display("Mismatch dac%0dSync: got %h expected %h",
                             d, dacSync[d], expSync[d]);
                end else if (expSync[d]) begin
                    checks++;
                    if (longint'(dacData[d]) != expData[d]) begin
                        errors++;
                        $display("Mismatch dac%0dData: got %h expected %h",
                                 d, dacData[d], sampleT'(expData[d]));
                    end
                end
            end
            if (rdCheck) begin
                checks++;
                if (dout !== rdExpect) begin
                    errors++;
                    $display("Mismatch dout at addr %h: got %h expected %h",
                             bus.addr, dout, rdExpect);
                end
            end
            // selectors see the stage values from before this edge
            for (int d = 0; d < 3; d++) begin
                case (sel[d])
                    `DAC_Q: begin
                        expData[d] = prevQ;
                        expSync[d] = videoEn;
                    end
                    `DAC_FMVIDEO: begin
                        expData[d] = video;
                        expSync[d] = videoEn;
                    end
                    `DAC_AVGFREQ: begin
                        expData[d] = avgF;
                        expSync[d] = avgEn;
                    end
                    `DAC_AVGABS: begin
                        expData[d] = avgA;
                        expSync[d] = avgEn;
                    end
                    default: begin
                        expData[d] = prevI;
                        expSync[d] = videoEn;
                    end
                endcase
            end
            // FM video is deviation, so no absolute input there
            absX = (mode == MODE_OQPSK || mode == MODE_SOQPSK) ?
                   ((video < 0) ? -video : video) : 0;
            if (videoEn) begin
                avgF = average(video, avgF, gainIn);
                avgA = average(absX, avgA, gainIn);
            end
            avgEn   = videoEn;
            videoEn = sampleEn;
            if (sampleEn) begin
                iNow  = iqSwap ? rx.q : rx.i;
                qNow  = iqSwap ? rx.i : rx.q;
                video = wrap18((prevI * qNow - prevQ * iNow) >>> 17);
                prevI = iNow;
                prevQ = qNow;
            end
            // writes land at this edge
            if (bus.wr && bus.addr[`ADDR_W-1:4] == `DEMOD_BASE) begin
                case (bus.addr[3:0])
                    `REG_CONTROL: begin
                        mode   = demodModeT'(bus.din[1:0]);
                        iqSwap = bus.din[2];
                    end
                    `REG_DACSEL: begin
                        sel[0] = bus.din[3:0];
                        sel[1] = bus.din[7:4];
                        sel[2] = bus.din[11:8];
                    end
                    `REG_ALPHA: gainIn = 4 * longint'(bus.din[15:0]);
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- source/demodTop.sv
module demodTop import demodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  demodBusT bus,
    output wordT     dout,
    input  iqSampleT rx,
    input  logic     sampleEn,
    input  logic     carrierLock,
    output sampleT   dac0Data,
    output sampleT   dac1Data,
    output sampleT   dac2Data,
    output logic     dac0Sync,
    output logic     dac1Sync,
    output logic     dac2Sync
);

    demodCfgT cfg;
    iqSampleT swapped;
    sampleT   video;
    logic     videoEn;
    sampleT   avgFreq;
    sampleT   avgAbsFreq;
    logic     avgEn;
    logic     highFreqOffset;

    demodRegs i_regs (
        .clk            (clk),
        .rstN           (rstN),
        .bus            (bus),
        .highFreqOffset (highFreqOffset),
        .carrierLock    (carrierLock),
        .cfg            (cfg),
        .dout           (dout)
    );

    fmDiscriminator i_disc (
        .clk      (clk),
        .rstN     (rstN),
        .cfg      (cfg),
        .rx       (rx),
        .sampleEn (sampleEn),
        .swapped  (swapped),
        .video    (video),
        .videoEn  (videoEn)
    );

    falseLockDetector i_fld (
        .clk            (clk),
        .rstN           (rstN),
        .cfg            (cfg),
        .video          (video),
        .videoEn        (videoEn),
        .carrierLock    (carrierLock),
        .avgFreq        (avgFreq),
        .avgAbsFreq     (avgAbsFreq),
        .avgEn          (avgEn),
        .highFreqOffset (highFreqOffset)
    );

    // three identical output selectors
    dacMux i_dac0 (
        .clk        (clk),
        .rstN       (rstN),
        .sel        (cfg.dac0Sel),
        .swapped    (swapped),
        .video      (video),
        .videoEn    (videoEn),
        .avgFreq    (avgFreq),
        .avgAbsFreq (avgAbsFreq),
        .avgEn      (avgEn),
        .dacData    (dac0Data),
        .dacSync    (dac0Sync)
    );

    dacMux i_dac1 (
        .clk        (clk),
        .rstN       (rstN),
        .sel        (cfg.dac1Sel),
        .swapped    (swapped),
        .video      (video),
        .videoEn    (videoEn),
        .avgFreq    (avgFreq),
        .avgAbsFreq (avgAbsFreq),
        .avgEn      (avgEn),
        .dacData    (dac1Data),
        .dacSync    (dac1Sync)
    );

    dacMux i_dac2 (
        .clk        (clk),
        .rstN       (rstN),
        .sel        (cfg.dac2Sel),
        .swapped    (swapped),
        .video      (video),
        .videoEn    (videoEn),
        .avgFreq    (avgFreq),
        .avgAbsFreq (avgAbsFreq),
        .avgEn      (avgEn),
        .dacData    (dac2Data),
        .dacSync    (dac2Sync)
    );

endmodule

//--- source/dacMux.sv
`include "demod_cfg.svh"

module dacMux import demodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  dacSelT   sel,
    input  iqSampleT swapped,
    input  sampleT   video,
    input  logic     videoEn,
    input  sampleT   avgFreq,
    input  sampleT   avgAbsFreq,
    input  logic     avgEn,
    output sampleT   dacData,
    output logic     dacSync
);

    sampleT nextData;
    logic   nextSync;

    // each source travels with the strobe that marks it valid
    always_comb begin
        case (sel)
            `DAC_Q: begin
                nextData = swapped.q;
                nextSync = videoEn;
            end
            `DAC_FMVIDEO: begin
                nextData = video;
                nextSync = videoEn;
            end
            `DAC_AVGFREQ: begin
                nextData = avgFreq;
                nextSync = avgEn;
            end
            `DAC_AVGABS: begin
                nextData = avgAbsFreq;
                nextSync = avgEn;
            end
            default: begin
                // DAC_I and any unused code
                nextData = swapped.i;
                nextSync = videoEn;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dacSync <= 1'b0;
        end else begin
            dacSync <= nextSync;
        end
    end

    always_ff @(posedge clk) begin
        dacData <= nextData;
    end

endmodule

//--- source/falseLockDetector.sv
`include "demod_cfg.svh"

module falseLockDetector import demodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  demodCfgT cfg,
    input  sampleT   video,
    input  logic     videoEn,
    input  logic     carrierLock,
    output sampleT   avgFreq,
    output sampleT   avgAbsFreq,
    output logic     avgEn,
    output logic     highFreqOffset
);

    localparam sampleT absLimit = `HIGH_ABS_LIMIT;

    logic signed [`SAMPLE_W:0]    gainIn;
    logic signed [`SAMPLE_W:0]    gainHold;
    logic signed [`SAMPLE_W:0]    videoExt;
    logic signed [`SAMPLE_W:0]    absIn;
    logic signed [`PRODUCT_W+1:0] freqSum;
    logic signed [`PRODUCT_W+1:0] absSum;
    logic [`SAMPLE_W-1:0]         avgFreqMag;

    // input gain 4*alpha, hold gain is the rest of unity
    assign gainIn   = $signed({1'b0, cfg.falseLockAlpha, 2'b00});
    assign gainHold = `ALPHA_ONE - gainIn;

    // one extra bit so the most negative video has a magnitude
    assign videoExt = video;

    always_comb begin
        case (cfg.mode)
            MODE_OQPSK,
            MODE_SOQPSK: begin
                absIn = videoExt[`SAMPLE_W] ? -videoExt : videoExt;
            end
            default: begin
                // FM video carries deviation, not offset
                absIn = '0;
            end
        endcase
    end

    assign freqSum = video * gainIn + avgFreq * gainHold;
    assign absSum  = absIn * gainIn + avgAbsFreq * gainHold;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            avgFreq    <= '0;
            avgAbsFreq <= '0;
            avgEn      <= 1'b0;
        end else begin
            avgEn <= videoEn;
            if (videoEn) begin
                // arithmetic shift by 17 gives the floor
                avgFreq    <= freqSum[`PRODUCT_W-2:`SAMPLE_W-1];
                avgAbsFreq <= absSum[`PRODUCT_W-2:`SAMPLE_W-1];
            end
        end
    end

    assign avgFreqMag = avgFreq[`SAMPLE_W-1] ? -avgFreq : avgFreq;

    // decision uses the averages stored on the previous edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            highFreqOffset <= 1'b0;
        end else if (avgEn) begin
            if (avgAbsFreq > absLimit) begin
                highFreqOffset <= 1'b1;
            end else if (avgFreqMag > {2'b00, cfg.falseLockThreshold}) begin
                highFreqOffset <= !carrierLock;
            end else begin
                highFreqOffset <= 1'b0;
            end
        end
    end

endmodule

//--- source/fmDiscriminator.sv
`include "demod_cfg.svh"

module fmDiscriminator import demodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  demodCfgT cfg,
    input  iqSampleT rx,
    input  logic     sampleEn,
    output iqSampleT swapped,
    output sampleT   video,
    output logic     videoEn
);

    sampleT                       iNow;
    sampleT                       qNow;
    logic signed [`PRODUCT_W-1:0] crossIQ;
    logic signed [`PRODUCT_W-1:0] crossQI;
    logic signed [`PRODUCT_W-1:0] diff;

    // optional i/q exchange ahead of the discriminator
    always_comb begin
        if (cfg.iqSwap) begin
            iNow = rx.q;
            qNow = rx.i;
        end else begin
            iNow = rx.i;
            qNow = rx.q;
        end
    end

    // swapped holds sample n-1 until the next strobe
    assign crossIQ = swapped.i * qNow;
    assign crossQI = swapped.q * iNow;
    assign diff    = crossIQ - crossQI;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            swapped <= '0;
            videoEn <= 1'b0;
        end else begin
            videoEn <= sampleEn;
            if (sampleEn) begin
                swapped <= {iNow, qNow};
            end
        end
    end

    // scale back to sample width, drop the duplicated sign bit
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            video <= diff[`PRODUCT_W-2:`SAMPLE_W-1];
        end
    end

    // the averager and decision pipeline needs three cycles per sample
    assert property (@(posedge clk) disable iff (!rstN)
        sampleEn |-> !$past(sampleEn) && !$past(sampleEn, 2));

endmodule

//--- source/demodRegs.sv
`include "demod_cfg.svh"

module demodRegs import demodPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  demodBusT bus,
    input  logic     highFreqOffset,
    input  logic     carrierLock,
    output demodCfgT cfg,
    output wordT     dout
);

    logic       demodSpace;
    logic [3:0] offset;
    logic       writeEn;

    // upper address byte picks the demod space
    assign demodSpace = (bus.addr[`ADDR_W-1:4] == `DEMOD_BASE);
    assign offset     = bus.addr[3:0];
    assign writeEn    = bus.wr && demodSpace;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfg <= '0;
        end else if (writeEn) begin
            case (offset)
                `REG_CONTROL: begin
                    cfg.mode   <= demodModeT'(bus.din[1:0]);
                    cfg.iqSwap <= bus.din[2];
                end
                `REG_DACSEL: begin
                    cfg.dac0Sel <= bus.din[3:0];
                    cfg.dac1Sel <= bus.din[7:4];
                    cfg.dac2Sel <= bus.din[11:8];
                end
                `REG_ALPHA: begin
                    cfg.falseLockAlpha <= bus.din[15:0];
                end
                `REG_THRESHOLD: begin
                    cfg.falseLockThreshold <= bus.din[15:0];
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

    // readback straight from the address
    always_comb begin
        dout = '0;
        if (demodSpace) begin
            case (offset)
                `REG_CONTROL:   dout[2:0]  = {cfg.iqSwap, cfg.mode};
                `REG_DACSEL:    dout[11:0] = {cfg.dac2Sel, cfg.dac1Sel, cfg.dac0Sel};
                `REG_ALPHA:     dout[15:0] = cfg.falseLockAlpha;
                `REG_THRESHOLD: dout[15:0] = cfg.falseLockThreshold;
                `REG_STATUS:    dout[1:0]  = {carrierLock, highFreqOffset};
                default:        dout       = '0;
            endcase
        end
    end

    // the fourth mode code has no datapath behind it
    assert property (@(posedge clk) disable iff (!rstN)
        (writeEn && offset == `REG_CONTROL) |-> bus.din[1:0] != 2'b11);

    // no bus writes while the block is held in reset
    assert property (@(posedge clk) !rstN |-> !bus.wr);

endmodule

//--- source/demodPkg.sv
`include "demod_cfg.svh"

package demodPkg;

    // baseband sample or video value
    typedef logic signed [`SAMPLE_W-1:0] sampleT;

    // processor bus fields
    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [`DATA_W-1:0] wordT;

    // averaging coefficient, gain is 4*a/2^17
    typedef logic [15:0] alphaT;

    typedef logic [3:0] dacSelT;

    typedef enum logic [1:0] {
        MODE_FM     = 2'd0,
        MODE_OQPSK  = 2'd1,
        MODE_SOQPSK = 2'd2
    } demodModeT;

    typedef struct packed {
        sampleT i;
        sampleT q;
    } iqSampleT;

    // register outputs seen by the datapath
    typedef struct packed {
        demodModeT   mode;
        logic        iqSwap;
        dacSelT      dac0Sel;
        dacSelT      dac1Sel;
        dacSelT      dac2Sel;
        alphaT       falseLockAlpha;
        logic [15:0] falseLockThreshold;
    } demodCfgT;

    typedef struct packed {
        logic wr;
        addrT addr;
        wordT din;
    } demodBusT;

endpackage

//--- source/demod_cfg.svh
`ifndef DEMOD_CFG_SVH
`define DEMOD_CFG_SVH

// datapath widths
`define SAMPLE_W        18
`define PRODUCT_W       36

// processor bus widths
`define ADDR_W          12
`define DATA_W          32

// upper address bits of the demod register space
`define DEMOD_BASE      8'h30

// register offsets inside the demod space
`define REG_CONTROL     4'd0
`define REG_DACSEL      4'd1
`define REG_ALPHA       4'd2
`define REG_THRESHOLD   4'd3
`define REG_STATUS      4'd4

// false lock limits, unit gain is 2^17
`define HIGH_ABS_LIMIT  18'h10000
`define ALPHA_ONE       19'sd131072

// dac source codes
`define DAC_I           4'd0
`define DAC_Q           4'd1
`define DAC_FMVIDEO     4'd2
`define DAC_AVGFREQ     4'd3
`define DAC_AVGABS      4'd4

`endif
